// ==== design/mcr3_settings.svh ====
/*
 * Port, joystick and download widths, download indices,
 * PS/2 scan codes and Max RPM gearbox codes
 */
`ifndef MCR3_SETTINGS_SVH
`define MCR3_SETTINGS_SVH

// Widths
`define PORT_W            8
`define JOY_W             10
`define DL_ADDR_W         25

// Download indices
`define DL_INDEX_GAME     8'd1
`define DL_INDEX_DIP      8'd254

// Player 1 keys
`define KEY_P1_UP         8'h75
`define KEY_P1_DOWN       8'h72
`define KEY_P1_LEFT       8'h6B
`define KEY_P1_RIGHT      8'h74
`define KEY_P1_FA         8'h14
`define KEY_P1_FB         8'h11
`define KEY_P1_FC         8'h29
`define KEY_P1_FD         8'h12

// Coins and starts, MAME style codes as alternates
`define KEY_COIN1         8'h76
`define KEY_COIN1_ALT     8'h2E
`define KEY_COIN2         8'h36
`define KEY_COIN3         8'h3D
`define KEY_START1        8'h05
`define KEY_START1_ALT    8'h16
`define KEY_START2        8'h06
`define KEY_START2_ALT    8'h1E

// Player 2 keys
`define KEY_P2_UP         8'h2D
`define KEY_P2_DOWN       8'h2B
`define KEY_P2_LEFT       8'h23
`define KEY_P2_RIGHT      8'h34
`define KEY_P2_FA         8'h1C
`define KEY_P2_FB         8'h1B
`define KEY_P2_FC         8'h21
`define KEY_P2_FD         8'h1D

// Max RPM gearbox
`define MAXRPM_GEAR_N      5
`define MAXRPM_GEAR_CODE_0 4'h0
`define MAXRPM_GEAR_CODE_1 4'h5
`define MAXRPM_GEAR_CODE_2 4'h6
`define MAXRPM_GEAR_CODE_3 4'h1
`define MAXRPM_GEAR_CODE_4 4'h2

`endif

// ==== design/mcr3_pkg.sv ====
/*
 * Game selection enum and joystick bit positions
 */
package mcr3_pkg;

	// Supported boards, download values above 3 fall back to Rampage
	typedef enum logic [1:0] {
		RAMPAGE    = 2'd0,
		SARGE      = 2'd1,
		POWERDRIVE = 2'd2,
		MAXRPM     = 2'd3
	} game_e;

	// Joystick word layout
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FA    = 4;
	localparam int JOY_FB    = 5;
	localparam int JOY_FC    = 6;
	localparam int JOY_FD    = 7;
	localparam int JOY_START = 8;
	localparam int JOY_COIN  = 9;

endpackage

// ==== design/player_if.sv ====
/*
 * Merged controls of one player
 */
`timescale 1ns/1ps

interface player_if;
	logic up;
	logic down;
	logic left;
	logic right;
	logic fire_a;
	logic fire_b;
	logic fire_c;
	logic fire_d;
	logic start;
	logic coin;

	modport source (output up, down, left, right, fire_a, fire_b, fire_c, fire_d, start, coin);
	modport sink   (input  up, down, left, right, fire_a, fire_b, fire_c, fire_d, start, coin);
endinterface

// ==== design/ps2_key_decoder.sv ====
/*
 * PS/2 key event decoder, holds keyboard button states
 */
`timescale 1ns/1ps
`include "mcr3_settings.svh"

module ps2_key_decoder (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic [10:0]         ps2_key,
	output logic [`JOY_W-1:0]   kb_p1,
	output logic [`JOY_W-1:0]   kb_p2,
	output logic                kb_coin2,
	output logic                kb_coin3
);
	import mcr3_pkg::*;

	logic       toggle_prev;
	logic       pressed;
	logic [7:0] code;

	assign pressed = ps2_key[9];
	assign code    = ps2_key[7:0];

	// A flip of bit 10 marks a new event
	always_ff @(posedge clk_sys) begin
		toggle_prev <= ps2_key[10];
		if (reset) begin
			kb_p1    <= '0;
			kb_p2    <= '0;
			kb_coin2 <= 1'b0;
			kb_coin3 <= 1'b0;
		end else if (toggle_prev != ps2_key[10]) begin
			case (code)
				`KEY_P1_UP:    kb_p1[JOY_UP]    <= pressed;
				`KEY_P1_DOWN:  kb_p1[JOY_DOWN]  <= pressed;
				`KEY_P1_LEFT:  kb_p1[JOY_LEFT]  <= pressed;
				`KEY_P1_RIGHT: kb_p1[JOY_RIGHT] <= pressed;
				`KEY_P1_FA:    kb_p1[JOY_FA]    <= pressed;
				`KEY_P1_FB:    kb_p1[JOY_FB]    <= pressed;
				`KEY_P1_FC:    kb_p1[JOY_FC]    <= pressed;
				`KEY_P1_FD:    kb_p1[JOY_FD]    <= pressed;
				`KEY_COIN1,
				`KEY_COIN1_ALT: kb_p1[JOY_COIN] <= pressed;
				`KEY_COIN2:    kb_coin2         <= pressed;
				`KEY_COIN3:    kb_coin3         <= pressed;
				`KEY_START1,
				`KEY_START1_ALT: kb_p1[JOY_START] <= pressed;
				`KEY_START2,
				`KEY_START2_ALT: kb_p2[JOY_START] <= pressed;
				`KEY_P2_UP:    kb_p2[JOY_UP]    <= pressed;
				`KEY_P2_DOWN:  kb_p2[JOY_DOWN]  <= pressed;
				`KEY_P2_LEFT:  kb_p2[JOY_LEFT]  <= pressed;
				`KEY_P2_RIGHT: kb_p2[JOY_RIGHT] <= pressed;
				`KEY_P2_FA:    kb_p2[JOY_FA]    <= pressed;
				`KEY_P2_FB:    kb_p2[JOY_FB]    <= pressed;
				`KEY_P2_FC:    kb_p2[JOY_FC]    <= pressed;
				`KEY_P2_FD:    kb_p2[JOY_FD]    <= pressed;
				// Unknown codes leave everything as is
				default: ;
			endcase
		end
	end

	// Coin 2 has its own output, so the coin bit of kb_p2 stays 0 after reset

endmodule

// ==== design/control_merge.sv ====
/*
 * Keyboard and joystick merge into three player control sets
 */
`timescale 1ns/1ps
`include "mcr3_settings.svh"

module control_merge (
	input  logic [`JOY_W-1:0] kb_p1,
	input  logic [`JOY_W-1:0] kb_p2,
	input  logic              kb_coin2,
	input  logic              kb_coin3,
	input  logic [`JOY_W-1:0] joy1,
	input  logic [`JOY_W-1:0] joy2,
	input  logic [`JOY_W-1:0] joy3,
	input  mcr3_pkg::game_e   game,
	player_if.source          p1,
	player_if.source          p2,
	player_if.source          p3
);
	import mcr3_pkg::*;

	logic [`JOY_W-1:0] m1;
	logic [`JOY_W-1:0] m2;
	logic              coin_any;
	logic              is_pd;

	// Player 3 has no keyboard keys
	assign m1 = kb_p1 | joy1;
	assign m2 = kb_p2 | joy2;

	assign is_pd    = (game == POWERDRIVE);
	assign coin_any = m1[JOY_COIN] | m2[JOY_COIN] | kb_coin2 | kb_coin3 | joy3[JOY_COIN];

	// ==================================================
	// Coin routing
	// ==================================================
	// Power Drive has one slot per player, the others share slot 1
	assign p1.coin = is_pd ? m1[JOY_COIN] : coin_any;
	assign p2.coin = is_pd & (m2[JOY_COIN] | kb_coin2);
	assign p3.coin = is_pd & (joy3[JOY_COIN] | kb_coin3);

	assign p1.up     = m1[JOY_UP];
	assign p1.down   = m1[JOY_DOWN];
	assign p1.left   = m1[JOY_LEFT];
	assign p1.right  = m1[JOY_RIGHT];
	assign p1.fire_a = m1[JOY_FA];
	assign p1.fire_b = m1[JOY_FB];
	assign p1.fire_c = m1[JOY_FC];
	assign p1.fire_d = m1[JOY_FD];
	assign p1.start  = m1[JOY_START];

	assign p2.up     = m2[JOY_UP];
	assign p2.down   = m2[JOY_DOWN];
	assign p2.left   = m2[JOY_LEFT];
	assign p2.right  = m2[JOY_RIGHT];
	assign p2.fire_a = m2[JOY_FA];
	assign p2.fire_b = m2[JOY_FB];
	assign p2.fire_c = m2[JOY_FC];
	assign p2.fire_d = m2[JOY_FD];
	assign p2.start  = m2[JOY_START];

	assign p3.up     = joy3[JOY_UP];
	assign p3.down   = joy3[JOY_DOWN];
	assign p3.left   = joy3[JOY_LEFT];
	assign p3.right  = joy3[JOY_RIGHT];
	assign p3.fire_a = joy3[JOY_FA];
	assign p3.fire_b = joy3[JOY_FB];
	assign p3.fire_c = joy3[JOY_FC];
	assign p3.fire_d = joy3[JOY_FD];
	assign p3.start  = joy3[JOY_START];

endmodule

// ==== design/game_config.sv ====
/*
 * Game selection and DIP bytes from the download bus
 */
`timescale 1ns/1ps
`include "mcr3_settings.svh"

module game_config (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_wr,
	input  logic [7:0]            dl_index,
	input  logic [`DL_ADDR_W-1:0] dl_addr,
	input  logic [7:0]            dl_data,
	output mcr3_pkg::game_e       game,
	output logic [7:0]            dip0,
	output logic                  dip1_bit0
);
	import mcr3_pkg::*;

	logic [7:0] game_sel;

	// Raw byte first, enum one cycle later
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game_sel <= 8'd0;
			game     <= RAMPAGE;
		end else begin
			if (dl_wr && dl_index == `DL_INDEX_GAME)
				game_sel <= dl_data;
			case (game_sel)
				8'd1:    game <= SARGE;
				8'd2:    game <= POWERDRIVE;
				8'd3:    game <= MAXRPM;
				default: game <= RAMPAGE;
			endcase
		end
	end

	// Only DIP bytes 0 and 1 are kept
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dip0      <= 8'd0;
			dip1_bit0 <= 1'b0;
		end else if (dl_wr && dl_index == `DL_INDEX_DIP) begin
			if (dl_addr == `DL_ADDR_W'(0))
				dip0 <= dl_data;
			else if (dl_addr == `DL_ADDR_W'(1))
				dip1_bit0 <= dl_data[0];
		end
	end

endmodule

// ==== design/gear_tracker.sv ====
/*
 * Power Drive gear toggles and Max RPM gearbox positions
 */
`timescale 1ns/1ps
`include "mcr3_settings.svh"

module gear_tracker (
	input  logic       clk_sys,
	input  logic       reset,
	player_if.sink     p1,
	player_if.sink     p2,
	player_if.sink     p3,
	output logic [2:0] pd_gear,
	output logic [3:0] rpm_code1,
	output logic [3:0] rpm_code2
);
	localparam logic [2:0] POS_MAX = 3'(`MAXRPM_GEAR_N - 1);

	logic [2:0] fire_d_now;
	logic [2:0] fire_d_prev;
	logic [1:0] fire_a_prev;
	logic [1:0] fire_b_prev;
	logic [2:0] rpm_pos1;
	logic [2:0] rpm_pos2;

	// Start resets, then shift up, then shift down
	function automatic logic [2:0] step_pos(
		input logic [2:0] pos,
		input logic       start,
		input logic       up,
		input logic       down
	);
		if (start)
			return 3'd0;
		else if (up && pos != POS_MAX)
			return pos + 3'd1;
		else if (down && pos != 3'd0)
			return pos - 3'd1;
		return pos;
	endfunction

	function automatic logic [3:0] gear_code(input logic [2:0] pos);
		case (pos)
			3'd1:    return `MAXRPM_GEAR_CODE_1;
			3'd2:    return `MAXRPM_GEAR_CODE_2;
			3'd3:    return `MAXRPM_GEAR_CODE_3;
			3'd4:    return `MAXRPM_GEAR_CODE_4;
			default: return `MAXRPM_GEAR_CODE_0;
		endcase
	endfunction

	assign fire_d_now = {p3.fire_d, p2.fire_d, p1.fire_d};

	always_ff @(posedge clk_sys) begin
		// Edge history follows the buttons even in reset
		fire_d_prev <= fire_d_now;
		fire_a_prev <= {p2.fire_a, p1.fire_a};
		fire_b_prev <= {p2.fire_b, p1.fire_b};
		if (reset) begin
			pd_gear  <= 3'd0;
			rpm_pos1 <= 3'd0;
			rpm_pos2 <= 3'd0;
		end else begin
			pd_gear  <= pd_gear ^ (fire_d_now & ~fire_d_prev);
			rpm_pos1 <= step_pos(rpm_pos1, p1.start,
				p1.fire_a & ~fire_a_prev[0], p1.fire_b & ~fire_b_prev[0]);
			rpm_pos2 <= step_pos(rpm_pos2, p2.start,
				p2.fire_a & ~fire_a_prev[1], p2.fire_b & ~fire_b_prev[1]);
		end
	end

	assign rpm_code1 = gear_code(rpm_pos1);
	assign rpm_code2 = gear_code(rpm_pos2);

endmodule

// ==== design/input_port_mapper.sv ====
/*
 * Game specific assembly of the five active low input ports,
 * Sarge dual stick remap included
 */
`timescale 1ns/1ps
`include "mcr3_settings.svh"

module input_port_mapper (
	input  mcr3_pkg::game_e     game,
	input  logic [7:0]          dip0,
	input  logic                dip1_bit0,
	input  logic                control_mode,
	player_if.sink              p1,
	player_if.sink              p2,
	player_if.sink              p3,
	input  logic [2:0]          pd_gear,
	input  logic [3:0]          rpm_code1,
	input  logic [3:0]          rpm_code2,
	output logic [`PORT_W-1:0]  input_0,
	output logic [`PORT_W-1:0]  input_1,
	output logic [`PORT_W-1:0]  input_2,
	output logic [`PORT_W-1:0]  input_3,
	output logic [`PORT_W-1:0]  input_4
);
	import mcr3_pkg::*;

	logic [3:0] sarge1;
	logic [3:0] sarge2;

	// Returns {rd, ru, ld, lu}
	function automatic logic [3:0] dual_stick(
		input logic mode,
		input logic up,
		input logic down,
		input logic left,
		input logic right,
		input logic fire_b,
		input logic fire_c
	);
		// Mode 1 derives both sticks from one diagonal joystick
		if (mode)
			return {down | right, up | left, down | left, up | right};
		return {fire_b, fire_c, down, up};
	endfunction

	assign sarge1 = dual_stick(control_mode, p1.up, p1.down, p1.left, p1.right,
		p1.fire_b, p1.fire_c);
	assign sarge2 = dual_stick(control_mode, p2.up, p2.down, p2.left, p2.right,
		p2.fire_b, p2.fire_c);

	assign input_3 = dip0;

	// ==================================================
	// Port layout per game
	// ==================================================
	always_comb begin
		input_0 = '1;
		input_1 = '1;
		input_2 = '1;
		input_4 = '1;
		case (game)
			SARGE: begin
				input_0 = ~{2'b00, dip1_bit0, 1'b0, p2.start, p1.start, p2.coin, p1.coin};
				input_1 = ~{p1.fire_d, p1.fire_d, p1.fire_a, p1.fire_a, sarge1};
				input_2 = ~{p2.fire_d, p2.fire_d, p2.fire_a, p2.fire_a, sarge2};
			end
			MAXRPM: begin
				// Pedal and steering ADC absent, input_1 idles high
				input_0 = ~{dip1_bit0, 3'b000, p1.start, p2.start, p1.coin, p2.coin};
				input_2 = ~{rpm_code1, rpm_code2};
			end
			POWERDRIVE: begin
				input_0 = ~{2'b00, dip1_bit0, 2'b00, p3.coin, p2.coin, p1.coin};
				input_1 = ~{p2.fire_b, p2.fire_a, pd_gear[1], p2.fire_c,
					p1.fire_b, p1.fire_a, pd_gear[0], p1.fire_c};
				input_2 = ~{4'b0000, p3.fire_b, p3.fire_a, pd_gear[2], p3.fire_c};
			end
			default: begin
				// Rampage, three players on plain joysticks
				input_0 = ~{2'b00, dip1_bit0, 3'b000, p2.coin, p1.coin};
				input_1 = ~{2'b00, p1.fire_b, p1.fire_a, p1.left, p1.down, p1.right, p1.up};
				input_2 = ~{2'b00, p2.fire_b, p2.fire_a, p2.left, p2.down, p2.right, p2.up};
				input_4 = ~{2'b00, p3.fire_b, p3.fire_a, p3.left, p3.down, p3.right, p3.up};
			end
		endcase
	end

endmodule

// ==== design/mcr3_inputs_top.sv ====
/*
 * Player input section top level
 */
`timescale 1ns/1ps
`include "mcr3_settings.svh"

module mcr3_inputs_top (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [10:0]           ps2_key,
	input  logic [`JOY_W-1:0]     joy1,
	input  logic [`JOY_W-1:0]     joy2,
	input  logic [`JOY_W-1:0]     joy3,
	input  logic                  control_mode,
	input  logic                  dl_wr,
	input  logic [7:0]            dl_index,
	input  logic [`DL_ADDR_W-1:0] dl_addr,
	input  logic [7:0]            dl_data,
	output logic [`PORT_W-1:0]    input_0,
	output logic [`PORT_W-1:0]    input_1,
	output logic [`PORT_W-1:0]    input_2,
	output logic [`PORT_W-1:0]    input_3,
	output logic [`PORT_W-1:0]    input_4
);
	import mcr3_pkg::*;

	logic [`JOY_W-1:0] kb_p1;
	logic [`JOY_W-1:0] kb_p2;
	logic              kb_coin2;
	logic              kb_coin3;
	game_e             game;
	logic [7:0]        dip0;
	logic              dip1_bit0;
	logic [2:0]        pd_gear;
	logic [3:0]        rpm_code1;
	logic [3:0]        rpm_code2;

	player_if p1 ();
	player_if p2 ();
	player_if p3 ();

	ps2_key_decoder u_keys (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ps2_key (ps2_key),
		.kb_p1   (kb_p1),
		.kb_p2   (kb_p2),
		.kb_coin2(kb_coin2),
		.kb_coin3(kb_coin3)
	);

	control_merge u_merge (
		.kb_p1   (kb_p1),
		.kb_p2   (kb_p2),
		.kb_coin2(kb_coin2),
		.kb_coin3(kb_coin3),
		.joy1    (joy1),
		.joy2    (joy2),
		.joy3    (joy3),
		.game    (game),
		.p1      (p1.source),
		.p2      (p2.source),
		.p3      (p3.source)
	);

	game_config u_config (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.game     (game),
		.dip0     (dip0),
		.dip1_bit0(dip1_bit0)
	);

	gear_tracker u_gears (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.p1       (p1.sink),
		.p2       (p2.sink),
		.p3       (p3.sink),
		.pd_gear  (pd_gear),
		.rpm_code1(rpm_code1),
		.rpm_code2(rpm_code2)
	);

	input_port_mapper u_ports (
		.game        (game),
		.dip0        (dip0),
		.dip1_bit0   (dip1_bit0),
		.control_mode(control_mode),
		.p1          (p1.sink),
		.p2          (p2.sink),
		.p3          (p3.sink),
		.pd_gear     (pd_gear),
		.rpm_code1   (rpm_code1),
		.rpm_code2   (rpm_code2),
		.input_0     (input_0),
		.input_1     (input_1),
		.input_2     (input_2),
		.input_3     (input_3),
		.input_4     (input_4)
	);

endmodule

// ==== tb/mcr3_inputs_tb.sv ====
/*
 * Random stimulus testbench for the player input section,
 * reference model of keys, controls, download state and gears
 */
`timescale 1ns/1ps
`include "mcr3_settings.svh"

module mcr3_inputs_tb;
	import mcr3_pkg::*;

	localparam int N_KEY       = 300;
	localparam int N_JOY       = 160;
	localparam int N_DL        = 150;
	localparam int N_SARGE     = 100;
	localparam int N_GEAR      = 300;
	localparam int WAIT_CYCLES = 4;
	// Six cycles per step at most, plus slack for game selects and directed steps
	localparam int PLANNED_CYCLES = 10 + 6 * (N_KEY + N_JOY + N_DL + N_SARGE + N_GEAR + 100);

	logic                  clk_sys;
	logic                  reset;
	logic [10:0]           ps2_key;
	logic [`JOY_W-1:0]     joy1;
	logic [`JOY_W-1:0]     joy2;
	logic [`JOY_W-1:0]     joy3;
	logic                  control_mode;
	logic                  dl_wr;
	logic [7:0]            dl_index;
	logic [`DL_ADDR_W-1:0] dl_addr;
	logic [7:0]            dl_data;
	logic [`PORT_W-1:0]    input_0;
	logic [`PORT_W-1:0]    input_1;
	logic [`PORT_W-1:0]    input_2;
	logic [`PORT_W-1:0]    input_3;
	logic [`PORT_W-1:0]    input_4;

	// Reference model state
	logic [`JOY_W-1:0] mk1, mk2;
	logic              mcoin2, mcoin3;
	logic [`JOY_W-1:0] mj1, mj2, mj3;
	logic [`JOY_W-1:0] prev1, prev2, prev3;
	game_e             mgame;
	logic [7:0]        mdip0;
	logic              mdip1;
	logic [2:0]        mpd;
	int                mpos1, mpos2;

	logic [7:0] known_codes [24] = '{
		`KEY_P1_UP, `KEY_P1_DOWN, `KEY_P1_LEFT, `KEY_P1_RIGHT,
		`KEY_P1_FA, `KEY_P1_FB, `KEY_P1_FC, `KEY_P1_FD,
		`KEY_COIN1, `KEY_COIN1_ALT, `KEY_COIN2, `KEY_COIN3,
		`KEY_START1, `KEY_START1_ALT, `KEY_START2, `KEY_START2_ALT,
		`KEY_P2_UP, `KEY_P2_DOWN, `KEY_P2_LEFT, `KEY_P2_RIGHT,
		`KEY_P2_FA, `KEY_P2_FB, `KEY_P2_FC, `KEY_P2_FD
	};

	mcr3_inputs_top uut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ps2_key     (ps2_key),
		.joy1        (joy1),
		.joy2        (joy2),
		.joy3        (joy3),
		.control_mode(control_mode),
		.dl_wr       (dl_wr),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.input_0     (input_0),
		.input_1     (input_1),
		.input_2     (input_2),
		.input_3     (input_3),
		.input_4     (input_4)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Twice the planned run length at 100 ns per cycle
	initial begin
		#(PLANNED_CYCLES * 200);
		$display("Timeout: the tests did not finish within the planned time");
		$display("TEST RESULT: FAIL");
		$fatal(1, "Watchdog expired");
	end

	// ==================================================
	// Reference model
	// ==================================================
	function automatic logic [3:0] rpm_lookup(input int pos);
		case (pos)
			1:       return `MAXRPM_GEAR_CODE_1;
			2:       return `MAXRPM_GEAR_CODE_2;
			3:       return `MAXRPM_GEAR_CODE_3;
			4:       return `MAXRPM_GEAR_CODE_4;
			default: return `MAXRPM_GEAR_CODE_0;
		endcase
	endfunction

	function automatic int next_pos(input int pos, input logic start, input logic up,
		input logic down);
		if (start)
			return 0;
		if (up && pos < `MAXRPM_GEAR_N - 1)
			return pos + 1;
		if (down && pos > 0)
			return pos - 1;
		return pos;
	endfunction

	// Rampage player byte before inversion is 0, 0, B, A, left, down, right, up
	function automatic logic [7:0] stick_byte(input logic [`JOY_W-1:0] c);
		return ~{2'b00, c[JOY_FB], c[JOY_FA], c[JOY_LEFT], c[JOY_DOWN], c[JOY_RIGHT], c[JOY_UP]};
	endfunction

	// Sarge byte with the left and right sticks {rd, ru, ld, lu}
	function automatic logic [7:0] sarge_byte(input logic [`JOY_W-1:0] c, input logic mode);
		logic [3:0] s;
		if (mode)
			s = {c[JOY_DOWN] | c[JOY_RIGHT], c[JOY_UP] | c[JOY_LEFT],
				c[JOY_DOWN] | c[JOY_LEFT], c[JOY_UP] | c[JOY_RIGHT]};
		else
			s = {c[JOY_FB], c[JOY_FC], c[JOY_DOWN], c[JOY_UP]};
		return ~{c[JOY_FD], c[JOY_FD], c[JOY_FA], c[JOY_FA], s};
	endfunction

	function automatic logic [`JOY_W-1:0] gear_word();
		logic [`JOY_W-1:0] w;
		w = '0;
		w[JOY_FA]    = $urandom % 2;
		w[JOY_FB]    = $urandom % 2;
		w[JOY_FD]    = $urandom % 2;
		w[JOY_START] = ($urandom % 10 == 0);
		return w;
	endfunction

	task automatic apply_key(input logic [7:0] code, input logic pressed);
		case (code)
			`KEY_P1_UP:    mk1[JOY_UP]    = pressed;
			`KEY_P1_DOWN:  mk1[JOY_DOWN]  = pressed;
			`KEY_P1_LEFT:  mk1[JOY_LEFT]  = pressed;
			`KEY_P1_RIGHT: mk1[JOY_RIGHT] = pressed;
			`KEY_P1_FA:    mk1[JOY_FA]    = pressed;
			`KEY_P1_FB:    mk1[JOY_FB]    = pressed;
			`KEY_P1_FC:    mk1[JOY_FC]    = pressed;
			`KEY_P1_FD:    mk1[JOY_FD]    = pressed;
			`KEY_COIN1, `KEY_COIN1_ALT:   mk1[JOY_COIN]  = pressed;
			`KEY_COIN2:    mcoin2         = pressed;
			`KEY_COIN3:    mcoin3         = pressed;
			`KEY_START1, `KEY_START1_ALT: mk1[JOY_START] = pressed;
			`KEY_START2, `KEY_START2_ALT: mk2[JOY_START] = pressed;
			`KEY_P2_UP:    mk2[JOY_UP]    = pressed;
			`KEY_P2_DOWN:  mk2[JOY_DOWN]  = pressed;
			`KEY_P2_LEFT:  mk2[JOY_LEFT]  = pressed;
			`KEY_P2_RIGHT: mk2[JOY_RIGHT] = pressed;
			`KEY_P2_FA:    mk2[JOY_FA]    = pressed;
			`KEY_P2_FB:    mk2[JOY_FB]    = pressed;
			`KEY_P2_FC:    mk2[JOY_FC]    = pressed;
			`KEY_P2_FD:    mk2[JOY_FD]    = pressed;
			default: ;
		endcase
	endtask

	// Gears react to rising edges of the merged controls
	task automatic update_gears();
		logic [`JOY_W-1:0] c1, c2, c3, r1, r2, r3;
		c1 = mk1 | mj1;
		c2 = mk2 | mj2;
		c3 = mj3;
		r1 = c1 & ~prev1;
		r2 = c2 & ~prev2;
		r3 = c3 & ~prev3;
		mpd   = mpd ^ {r3[JOY_FD], r2[JOY_FD], r1[JOY_FD]};
		mpos1 = next_pos(mpos1, c1[JOY_START], r1[JOY_FA], r1[JOY_FB]);
		mpos2 = next_pos(mpos2, c2[JOY_START], r2[JOY_FA], r2[JOY_FB]);
		prev1 = c1;
		prev2 = c2;
		prev3 = c3;
	endtask

	// ==================================================
	// Checking
	// ==================================================
	task automatic check_value(input string name, input string port,
		input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s %s expected %h actual %h", name, port, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic check_ports(input string name);
		logic [`JOY_W-1:0] c1, c2, c3;
		logic              co1, co2, co3;
		logic [7:0]        e0, e1, e2, e4;
		c1 = mk1 | mj1;
		c2 = mk2 | mj2;
		c3 = mj3;
		// Power Drive has a slot per player, other games share slot 1
		if (mgame == POWERDRIVE) begin
			co1 = c1[JOY_COIN];
			co2 = mcoin2 | c2[JOY_COIN];
			co3 = mcoin3 | c3[JOY_COIN];
		end else begin
			co1 = c1[JOY_COIN] | c2[JOY_COIN] | c3[JOY_COIN] | mcoin2 | mcoin3;
			co2 = 1'b0;
			co3 = 1'b0;
		end
		e1 = 8'hFF;
		e2 = 8'hFF;
		e4 = 8'hFF;
		case (mgame)
			SARGE: begin
				e0 = ~{2'b00, mdip1, 1'b0, c2[JOY_START], c1[JOY_START], co2, co1};
				e1 = sarge_byte(c1, control_mode);
				e2 = sarge_byte(c2, control_mode);
			end
			MAXRPM: begin
				e0 = ~{mdip1, 3'b000, c1[JOY_START], c2[JOY_START], co1, co2};
				e2 = ~{rpm_lookup(mpos1), rpm_lookup(mpos2)};
			end
			POWERDRIVE: begin
				e0 = ~{2'b00, mdip1, 2'b00, co3, co2, co1};
				e1 = ~{c2[JOY_FB], c2[JOY_FA], mpd[1], c2[JOY_FC],
					c1[JOY_FB], c1[JOY_FA], mpd[0], c1[JOY_FC]};
				e2 = ~{4'b0000, c3[JOY_FB], c3[JOY_FA], mpd[2], c3[JOY_FC]};
			end
			default: begin
				e0 = ~{2'b00, mdip1, 3'b000, co2, co1};
				e1 = stick_byte(c1);
				e2 = stick_byte(c2);
				e4 = stick_byte(c3);
			end
		endcase
		check_value(name, "input_0", e0, input_0);
		check_value(name, "input_1", e1, input_1);
		check_value(name, "input_2", e2, input_2);
		check_value(name, "input_3", mdip0, input_3);
		check_value(name, "input_4", e4, input_4);
	endtask

	task automatic settle_and_check(input string name);
		repeat (WAIT_CYCLES) @(negedge clk_sys);
		check_ports(name);
	endtask

	// ==================================================
	// Stimulus tasks for the falling edge
	// ==================================================
	task automatic send_key(input logic [7:0] code, input logic pressed);
		ps2_key = {~ps2_key[10], pressed, 1'b0, code};
		apply_key(code, pressed);
		update_gears();
	endtask

	task automatic drive_joys(input logic [`JOY_W-1:0] a, input logic [`JOY_W-1:0] b,
		input logic [`JOY_W-1:0] c);
		joy1 = a;
		joy2 = b;
		joy3 = c;
		mj1  = a;
		mj2  = b;
		mj3  = c;
		update_gears();
	endtask

	task automatic download_write(input logic [7:0] index, input logic [`DL_ADDR_W-1:0] addr,
		input logic [7:0] data);
		dl_wr    = 1'b1;
		dl_index = index;
		dl_addr  = addr;
		dl_data  = data;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		if (index == `DL_INDEX_GAME)
			mgame = (data <= 8'd3) ? game_e'(data[1:0]) : RAMPAGE;
		else if (index == `DL_INDEX_DIP && addr == 0)
			mdip0 = data;
		else if (index == `DL_INDEX_DIP && addr == 1)
			mdip1 = data[0];
	endtask

	task automatic select_game(input game_e g);
		download_write(`DL_INDEX_GAME, '0, 8'(g));
		settle_and_check("game select");
	endtask

	task automatic release_all_keys();
		foreach (known_codes[i]) begin
			send_key(known_codes[i], 1'b0);
			settle_and_check("key release");
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		logic [7:0]            code, idx, data;
		logic [`DL_ADDR_W-1:0] addr;
		logic [`JOY_W-1:0]     fa, fb, st;
		int                    sel;
		void'($urandom(53732));
		reset        = 1'b1;
		ps2_key      = '0;
		joy1         = '0;
		joy2         = '0;
		joy3         = '0;
		control_mode = 1'b0;
		dl_wr        = 1'b0;
		dl_index     = '0;
		dl_addr      = '0;
		dl_data      = '0;
		mk1 = '0;
		mk2 = '0;
		mj1 = '0;
		mj2 = '0;
		mj3 = '0;
		prev1 = '0;
		prev2 = '0;
		prev3 = '0;
		mcoin2 = 1'b0;
		mcoin3 = 1'b0;
		mgame  = RAMPAGE;
		mdip0  = '0;
		mdip1  = 1'b0;
		mpd    = '0;
		mpos1  = 0;
		mpos2  = 0;
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;

		// Rampage with nothing pressed
		repeat (2) @(negedge clk_sys);
		check_value("reset defaults", "input_0", 8'hFF, input_0);
		check_value("reset defaults", "input_1", 8'hFF, input_1);
		check_value("reset defaults", "input_2", 8'hFF, input_2);
		check_value("reset defaults", "input_3", 8'h00, input_3);
		check_value("reset defaults", "input_4", 8'hFF, input_4);

		// Known and unknown scan codes
		for (int i = 0; i < N_KEY; i++) begin
			code = ($urandom % 5 == 0) ? $urandom : known_codes[$urandom % 24];
			send_key(code, $urandom % 2);
			settle_and_check("keyboard decoding");
		end

		for (int g = 0; g < 4; g++) begin
			select_game(game_e'(g));
			for (int i = 0; i < N_JOY / 4; i++) begin
				control_mode = $urandom % 2;
				drive_joys($urandom, $urandom, $urandom);
				// Keyboard coin keys take part in the coin routing
				send_key(known_codes[8 + $urandom % 4], $urandom % 2);
				settle_and_check("control merging");
			end
		end

		for (int i = 0; i < N_DL; i++) begin
			sel  = $urandom % 3;
			idx  = (sel == 0) ? $urandom : ((sel == 1) ? `DL_INDEX_GAME : `DL_INDEX_DIP);
			addr = ($urandom % 4 == 0) ? $urandom : $urandom % 3;
			data = ($urandom % 2) ? $urandom % 6 : $urandom;
			download_write(idx, addr, data);
			settle_and_check("game and dip writes");
		end

		select_game(SARGE);
		for (int m = 0; m < 2; m++) begin
			control_mode = m;
			for (int i = 0; i < N_SARGE / 2; i++) begin
				drive_joys($urandom, $urandom, $urandom);
				settle_and_check("sarge dual stick");
			end
		end

		// Gears from a clean control state
		release_all_keys();
		drive_joys('0, '0, '0);
		settle_and_check("gear idle");
		select_game(POWERDRIVE);
		for (int i = 0; i < N_GEAR / 2; i++) begin
			drive_joys(gear_word(), gear_word(), gear_word());
			settle_and_check("power drive gears");
		end
		select_game(MAXRPM);
		for (int i = 0; i < N_GEAR / 2; i++) begin
			drive_joys(gear_word(), gear_word(), gear_word());
			settle_and_check("max rpm gears");
		end

		// Push both gearboxes past the top, then past the bottom
		fa = '0;
		fb = '0;
		st = '0;
		fa[JOY_FA]    = 1'b1;
		fb[JOY_FB]    = 1'b1;
		st[JOY_START] = 1'b1;
		drive_joys('0, '0, '0);
		settle_and_check("gearbox release");
		repeat (6) begin
			drive_joys(fa, fa, '0);
			settle_and_check("gearbox up");
			drive_joys('0, '0, '0);
			settle_and_check("gearbox up");
		end
		check_value("gearbox top", "input_2",
			~{`MAXRPM_GEAR_CODE_4, `MAXRPM_GEAR_CODE_4}, input_2);
		repeat (6) begin
			drive_joys(fb, fb, '0);
			settle_and_check("gearbox down");
			drive_joys('0, '0, '0);
			settle_and_check("gearbox down");
		end
		check_value("gearbox bottom", "input_2", 8'hFF, input_2);
		repeat (2) begin
			drive_joys(fa, fa, '0);
			settle_and_check("gearbox up");
			drive_joys('0, '0, '0);
			settle_and_check("gearbox up");
		end
		drive_joys(st, st, '0);
		settle_and_check("gearbox start");
		check_value("gearbox start", "input_2", 8'hFF, input_2);
		drive_joys('0, '0, '0);
		settle_and_check("gearbox start");

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+design
design/mcr3_pkg.sv
design/player_if.sv
design/ps2_key_decoder.sv
design/control_merge.sv
design/game_config.sv
design/gear_tracker.sv
design/input_port_mapper.sv
design/mcr3_inputs_top.sv
tb/mcr3_inputs_tb.sv
